// ==== Bender.yml ====
package:
  name: soc_io

sources:
  - design/soc_io_pkg.sv
  - design/bus_decoder.sv
  - design/boot_mem.sv
  - design/sys_ctrl.sv
  - design/spi_flash_ctrl.sv
  - design/soc_io_top.sv
  - target: test
    files:
      - bench/tb_clk_rst.sv
      - bench/soc_io_props.sv
      - bench/tb_soc_io.sv

// ==== bench/soc_io_props.sv ====
`timescale 1ns/100ps

module soc_io_props (
   input logic                 clk,
   input logic                 i_rst_n,
   input soc_io_pkg::wb_req_t  i_wb,
   input soc_io_pkg::wb_rsp_t  o_wb,
   input logic [31:0]          o_gpio,
   input logic                 o_flash_sclk,
   input logic                 o_flash_cs_n,
   input logic                 o_timer_irq,
   input soc_io_pkg::ext_irq_t o_ext_irq
);
   import soc_io_pkg::*;

   // ************************************************
   // Bus handshake
   // ************************************************
   ack_one_cycle: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_wb.ack |=> !o_wb.ack)
      else $error("ack stayed high for two cycles");

   // Fixed latency, every strobe gets its ack on the next clock
   ack_after_stb: assert property (@(posedge clk) disable iff (!i_rst_n)
      (i_wb.cyc && i_wb.stb && !o_wb.ack) |=> o_wb.ack)
      else $error("ack did not follow stb by one cycle");

   ack_needs_stb: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_wb.ack |-> $past(i_wb.cyc && i_wb.stb))
      else $error("ack without a preceding strobe");

   // ************************************************
   // Quiet outputs out of reset
   // ************************************************
   reset_idle: assert property (@(posedge clk)
      !i_rst_n |=> (!o_wb.ack && o_ext_irq == '0 && !o_timer_irq && !o_flash_sclk
                    && o_flash_cs_n && o_gpio == '0))
      else $error("outputs not idle after a reset cycle");

endmodule

bind soc_io_top soc_io_props u_props (.*);

// ==== bench/tb_clk_rst.sv ====
`timescale 1ns/100ps

module tb_clk_rst #(
   parameter int PERIOD_NS  = 20,
   parameter int RST_CYCLES = 3
) (
   output logic clk,
   output logic o_rst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // Reset held low for a few clocks, then released on an edge
   initial begin
      o_rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      o_rst_n <= 1'b1;
   end

endmodule

// ==== bench/tb_soc_io.sv ====
`timescale 1ns/100ps

module tb_soc_io;
   import soc_io_pkg::*;

   localparam int ACK_TIMEOUT  = 16;
   localparam int RST_TIMEOUT  = 16;
   localparam int POLL_LIMIT   = 64;
   localparam int BOOT_ENTRIES = 8;

   // One bus access of the stimulus table
   typedef struct packed {
      logic              we;
      logic [ADDR_W-1:0] adr;
      logic [DATA_W-1:0] dat;
      logic [SEL_W-1:0]  sel;
      logic [DATA_W-1:0] exp;
   } xfer_t;

   logic        clk;
   logic        rst_n;
   wb_req_t     wb_req;
   wb_rsp_t     wb_rsp;
   logic [31:0] gpio_in;
   logic [31:0] gpio_out;
   logic        ram_init_done;
   logic        ram_init_error;
   logic        flash_sclk;
   logic        flash_cs_n;
   logic        flash_mosi;
   logic        timer_irq;
   ext_irq_t    ext_irq;
   logic [31:0] rng_state = 32'd69;
   xfer_t       xfer_q[$];

   tb_clk_rst u_clk_rst (
      .clk     (clk),
      .o_rst_n (rst_n)
   );

   // MOSI looped back onto MISO
   soc_io_top uut (
      .clk              (clk),
      .i_rst_n          (rst_n),
      .i_wb             (wb_req),
      .o_wb             (wb_rsp),
      .i_gpio           (gpio_in),
      .o_gpio           (gpio_out),
      .i_ram_init_done  (ram_init_done),
      .i_ram_init_error (ram_init_error),
      .i_flash_miso     (flash_mosi),
      .o_flash_sclk     (flash_sclk),
      .o_flash_cs_n     (flash_cs_n),
      .o_flash_mosi     (flash_mosi),
      .o_timer_irq      (timer_irq),
      .o_ext_irq        (ext_irq)
   );

   // ************************************************
   // Helpers
   // ************************************************
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function logic [31:0] next_rand();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                               input logic [31:0] new_w,
                                               input logic [3:0]  sel);
      logic [31:0] mask;
      mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
      return (old_w & ~mask) | (new_w & mask);
   endfunction

   function automatic logic [ADDR_W-1:0] sys_addr(input sys_reg_e r);
      return SYS_BASE | ADDR_W'(r);
   endfunction

   function automatic logic [ADDR_W-1:0] spi_addr(input spi_reg_e r);
      return SPI_BASE | ADDR_W'(r);
   endfunction

   function void add_entry(input logic we, input logic [ADDR_W-1:0] adr,
                           input logic [DATA_W-1:0] dat, input logic [SEL_W-1:0] sel,
                           input logic [DATA_W-1:0] exp);
      xfer_q.push_back('{we: we, adr: adr, dat: dat, sel: sel, exp: exp});
   endfunction

   task automatic stop_on_mismatch(input string msg);
      $display("Error at %0t ns: %s", $time, msg);
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation stopped at first mismatch");
   endtask

   task automatic stop_on_timeout(input string msg);
      $display("Gave up %s at %0t ns, the DUT never answered", msg, $time);
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation stopped on timeout");
   endtask

   task automatic check_rsp(input wb_rsp_t got, input wb_rsp_t exp, input logic with_rdt,
                            input string what);
      if (got.ack !== exp.ack || (with_rdt && got.rdt !== exp.rdt)) begin
         stop_on_mismatch($sformatf("%s: got ack %b rdt %h, expected ack %b rdt %h",
                                    what, got.ack, got.rdt, exp.ack, exp.rdt));
      end
   endtask

   task automatic check_irq(input ext_irq_t got, input ext_irq_t exp, input string what);
      if (got !== exp) begin
         stop_on_mismatch($sformatf("%s: irq %b, expected %b", what, got, exp));
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         stop_on_mismatch($sformatf("%s: got %b, expected %b", what, got, exp));
      end
   endtask

   task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         stop_on_mismatch($sformatf("%s: got %h, expected %h", what, got, exp));
      end
   endtask

   // Ack is due one clk after the DUT first samples stb
   task automatic bus_xfer(input logic we, input logic [ADDR_W-1:0] adr,
                           input logic [DATA_W-1:0] dat, input logic [SEL_W-1:0] sel,
                           output wb_rsp_t rsp);
      int waited;
      waited = 0;
      @(posedge clk);
      wb_req <= '{adr: adr, dat: dat, sel: sel, we: we, cyc: 1'b1, stb: 1'b1};
      @(negedge clk);
      while (!wb_rsp.ack) begin
         waited++;
         if (waited > ACK_TIMEOUT) stop_on_timeout($sformatf("waiting for ack at %h", adr));
         @(negedge clk);
      end
      if (waited != 1) stop_on_mismatch($sformatf("ack at %h after %0d cycles", adr, waited));
      rsp = wb_rsp;
      @(posedge clk);
      wb_req.cyc <= 1'b0;
      wb_req.stb <= 1'b0;
   endtask

   task automatic run_table(input string what);
      wb_rsp_t rsp;
      wb_rsp_t exp;
      foreach (xfer_q[i]) begin
         bus_xfer(xfer_q[i].we, xfer_q[i].adr, xfer_q[i].dat, xfer_q[i].sel, rsp);
         exp = '{rdt: xfer_q[i].exp, ack: 1'b1};
         check_rsp(rsp, exp, !xfer_q[i].we, $sformatf("%s entry %0d", what, i));
      end
      xfer_q.delete();
   endtask

   // ************************************************
   // Test sequence
   // ************************************************
   initial begin
      logic [31:0] boot_model [BOOT_ENTRIES];
      logic [31:0] word;
      logic [31:0] gpio_val;
      logic [31:0] gpio_drive;
      logic [31:0] status;
      logic [7:0]  spi_byte;
      logic [1:0]  swirq_vals [3];
      ext_irq_t    exp_irq;
      wb_rsp_t     rsp;
      wb_rsp_t     rsp2;
      int          waited;
      int          polls;

      wb_req         = '0;
      gpio_in        = '0;
      ram_init_done  = 1'b0;
      ram_init_error = 1'b0;
      swirq_vals     = '{2'd1, 2'd2, 2'd0};

      waited = 0;
      while (rst_n !== 1'b1) begin
         waited++;
         if (waited > RST_TIMEOUT) stop_on_timeout("waiting for reset release");
         @(negedge clk);
      end
      @(negedge clk);
      check_irq(ext_irq, '0, "irq after reset");
      check_bit(timer_irq, 1'b0, "timer irq after reset");
      check_bit(flash_cs_n, 1'b1, "flash cs_n after reset");
      check_bit(flash_sclk, 1'b0, "flash sclk after reset");

      gpio_drive = next_rand();
      status     = next_rand() & 32'd3;
      @(posedge clk);
      gpio_in        <= gpio_drive;
      ram_init_done  <= status[0];
      ram_init_error <= status[1];

      // Full words first, then random byte lanes over them
      for (int i = 0; i < BOOT_ENTRIES; i++) begin
         boot_model[i] = next_rand();
         add_entry(1'b1, BOOT_BASE + ADDR_W'(i * 'h84), boot_model[i], 4'hF, '0);
      end
      for (int i = 0; i < BOOT_ENTRIES; i++) begin
         word          = next_rand();
         gpio_val      = next_rand();
         boot_model[i] = merge_bytes(boot_model[i], gpio_val, word[3:0]);
         add_entry(1'b1, BOOT_BASE + ADDR_W'(i * 'h84), gpio_val, word[3:0], '0);
      end
      for (int i = 0; i < BOOT_ENTRIES; i++) begin
         add_entry(1'b0, BOOT_BASE + ADDR_W'(i * 'h84), '0, 4'hF, boot_model[i]);
      end
      run_table("boot memory");

      gpio_val = next_rand();
      add_entry(1'b1, sys_addr(SYS_GPIO_OUT), gpio_val, 4'hF, '0);
      add_entry(1'b0, sys_addr(SYS_GPIO_OUT), '0, 4'hF, gpio_val);
      add_entry(1'b0, sys_addr(SYS_GPIO_IN), '0, 4'hF, gpio_drive);
      add_entry(1'b0, sys_addr(SYS_STATUS), '0, 4'hF, status);
      add_entry(1'b1, 16'h3004, next_rand(), 4'hF, '0);
      add_entry(1'b0, 16'h3004, '0, 4'hF, '0);
      add_entry(1'b0, 16'h3000, '0, 4'hF, '0);
      run_table("gpio and status");
      @(negedge clk);
      check_word(gpio_out, gpio_val, "gpio output pins");

      foreach (swirq_vals[k]) begin
         bus_xfer(1'b1, sys_addr(SYS_SWIRQ), {30'd0, swirq_vals[k]}, 4'hF, rsp);
         @(negedge clk);
         exp_irq = '{spi: 1'b0, sw3: swirq_vals[k][0], sw4: swirq_vals[k][1]};
         check_irq(ext_irq, exp_irq, "software interrupts");
      end

      bus_xfer(1'b1, sys_addr(SYS_MTIMECMP), '0, 4'hF, rsp);
      @(negedge clk);
      check_bit(timer_irq, 1'b1, "timer irq with compare at zero");
      bus_xfer(1'b1, sys_addr(SYS_MTIMECMP), '1, 4'hF, rsp);
      @(negedge clk);
      check_bit(timer_irq, 1'b0, "timer irq with compare at all ones");
      bus_xfer(1'b0, sys_addr(SYS_MTIME), '0, 4'hF, rsp);
      bus_xfer(1'b0, sys_addr(SYS_MTIME), '0, 4'hF, rsp2);
      if (rsp2.rdt <= rsp.rdt) begin
         stop_on_mismatch($sformatf("mtime went from %h to %h", rsp.rdt, rsp2.rdt));
      end

      // SPI loopback of one random byte
      word     = next_rand();
      spi_byte = word[7:0];
      bus_xfer(1'b1, spi_addr(SPI_SEL), 32'd1, 4'hF, rsp);
      @(negedge clk);
      check_bit(flash_cs_n, 1'b0, "flash cs_n when selected");
      bus_xfer(1'b1, spi_addr(SPI_CTRL), 32'd1, 4'hF, rsp);
      bus_xfer(1'b1, spi_addr(SPI_DATA), {24'd0, spi_byte}, 4'h1, rsp);
      polls = 0;
      rsp   = '0;
      while (rsp.rdt[0] !== 1'b1) begin
         polls++;
         if (polls > POLL_LIMIT) stop_on_timeout("polling the SPI done flag");
         bus_xfer(1'b0, spi_addr(SPI_STAT), '0, 4'hF, rsp);
      end
      @(negedge clk);
      exp_irq = '{spi: 1'b1, sw3: 1'b0, sw4: 1'b0};
      check_irq(ext_irq, exp_irq, "spi done interrupt");
      check_bit(flash_sclk, 1'b0, "flash sclk after transfer");

      add_entry(1'b0, spi_addr(SPI_DATA), '0, 4'hF, {24'd0, spi_byte});
      add_entry(1'b1, spi_addr(SPI_STAT), 32'd1, 4'hF, '0);
      run_table("spi loopback");
      @(negedge clk);
      check_irq(ext_irq, '0, "spi interrupt after clearing done");

      // Bit 2 set reads SPI_CTRL and leaves the data register alone
      add_entry(1'b0, spi_addr(SPI_STAT), '0, 4'hF, '0);
      add_entry(1'b0, spi_addr(SPI_DATA) + 16'h4, '0, 4'hF, 32'd1);
      add_entry(1'b0, spi_addr(SPI_DATA), '0, 4'hF, {24'd0, spi_byte});
      run_table("spi read redirect");

      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

// ==== build.f ====
design/soc_io_pkg.sv
design/bus_decoder.sv
design/boot_mem.sv
design/sys_ctrl.sv
design/spi_flash_ctrl.sv
design/soc_io_top.sv
bench/tb_clk_rst.sv
bench/soc_io_props.sv
bench/tb_soc_io.sv

// ==== design/boot_mem.sv ====
`timescale 1ns/100ps

module boot_mem (
   input  logic                clk,
   input  logic                i_rst_n,
   input  soc_io_pkg::wb_req_t i_req,
   output soc_io_pkg::wb_rsp_t o_rsp
);
   import soc_io_pkg::*;

   logic [DATA_W-1:0]     mem [BOOT_MEM_WORDS];
   logic [DATA_W-1:0]     rd_q;
   logic [BOOT_IDX_W-1:0] idx;
   logic                  ack_q;

   assign idx = i_req.adr[BOOT_IDX_W+1:2];

   // Byte lanes written per sel
   always_ff @(posedge clk) begin
      if (i_req.cyc && i_req.stb && i_req.we && !ack_q) begin
         for (int b = 0; b < SEL_W; b++) begin
            if (i_req.sel[b]) begin
               mem[idx][8*b +: 8] <= i_req.dat[8*b +: 8];
            end
         end
      end
      rd_q <= mem[idx];
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= i_req.cyc & i_req.stb & ~ack_q;
      end
   end

   assign o_rsp.ack = ack_q;
   assign o_rsp.rdt = ack_q ? rd_q : '0;

endmodule

// ==== design/bus_decoder.sv ====
`timescale 1ns/100ps

module bus_decoder (
   input  logic                clk,
   input  logic                i_rst_n,
   input  soc_io_pkg::wb_req_t i_host,
   output soc_io_pkg::wb_rsp_t o_host,
   output soc_io_pkg::wb_req_t o_boot_req,
   output soc_io_pkg::wb_req_t o_sys_req,
   output soc_io_pkg::wb_req_t o_spi_req,
   input  soc_io_pkg::wb_rsp_t i_boot_rsp,
   input  soc_io_pkg::wb_rsp_t i_sys_rsp,
   input  soc_io_pkg::wb_rsp_t i_spi_rsp
);
   import soc_io_pkg::*;

   logic [ADDR_W-1:0] region;
   logic              hit_boot;
   logic              hit_sys;
   logic              hit_spi;
   logic              hit_none;
   logic              none_ack_q;

   assign region   = i_host.adr & REGION_MASK;
   assign hit_boot = (region == BOOT_BASE);
   assign hit_sys  = (region == SYS_BASE);
   assign hit_spi  = (region == SPI_BASE);
   assign hit_none = !(hit_boot || hit_sys || hit_spi);

   // Only the selected device sees stb
   always_comb begin
      o_boot_req     = i_host;
      o_sys_req      = i_host;
      o_spi_req      = i_host;
      o_boot_req.stb = i_host.stb & hit_boot;
      o_sys_req.stb  = i_host.stb & hit_sys;
      o_spi_req.stb  = i_host.stb & hit_spi;
   end

   // Unmapped hole answers by itself, data zero
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         none_ack_q <= 1'b0;
      end else begin
         none_ack_q <= i_host.cyc & i_host.stb & hit_none & ~none_ack_q;
      end
   end

   // Address is held until ack, so it still picks the right responder
   always_comb begin
      if (hit_boot) begin
         o_host = i_boot_rsp;
      end else if (hit_sys) begin
         o_host = i_sys_rsp;
      end else if (hit_spi) begin
         o_host = i_spi_rsp;
      end else begin
         o_host = '{rdt: '0, ack: none_ack_q};
      end
   end

endmodule

// ==== design/soc_io_pkg.sv ====
package soc_io_pkg;

   // ************************************************
   // Bus geometry and address map
   // ************************************************
   localparam int ADDR_W = 16;
   localparam int DATA_W = 32;
   localparam int SEL_W  = 4;

   localparam int BOOT_MEM_WORDS = 1024;
   localparam int BOOT_IDX_W     = $clog2(BOOT_MEM_WORDS);

   // Each region covers 4 KiB
   localparam logic [ADDR_W-1:0] BOOT_BASE   = 16'h0000;
   localparam logic [ADDR_W-1:0] SYS_BASE    = 16'h1000;
   localparam logic [ADDR_W-1:0] SPI_BASE    = 16'h2000;
   localparam logic [ADDR_W-1:0] REGION_MASK = 16'hF000;

   // clk cycles per SCLK phase
   localparam int SPI_HALF_PERIOD = 2;
   localparam int SPI_DIV_W = (SPI_HALF_PERIOD > 1) ? $clog2(SPI_HALF_PERIOD) : 1;

   // ************************************************
   // Bus and interrupt types
   // ************************************************
   typedef struct packed {
      logic [ADDR_W-1:0] adr;
      logic [DATA_W-1:0] dat;
      logic [SEL_W-1:0]  sel;
      logic              we;
      logic              cyc;
      logic              stb;
   } wb_req_t;

   typedef struct packed {
      logic [DATA_W-1:0] rdt;
      logic              ack;
   } wb_rsp_t;

   typedef struct packed {
      logic spi;
      logic sw3;
      logic sw4;
   } ext_irq_t;

   // System controller word offsets
   typedef enum logic [4:0] {
      SYS_STATUS   = 5'h00,
      SYS_SWIRQ    = 5'h04,
      SYS_GPIO_OUT = 5'h08,
      SYS_GPIO_IN  = 5'h0C,
      SYS_MTIME    = 5'h10,
      SYS_MTIMECMP = 5'h18
   } sys_reg_e;

   // SPI registers sit 8 bytes apart
   typedef enum logic [4:0] {
      SPI_CTRL = 5'h00,
      SPI_STAT = 5'h08,
      SPI_DATA = 5'h10,
      SPI_SEL  = 5'h18
   } spi_reg_e;

   typedef enum logic [1:0] {
      SPI_IDLE,
      SPI_SHIFT,
      SPI_FINISH
   } spi_state_e;

endpackage

// ==== design/soc_io_top.sv ====
`timescale 1ns/100ps

module soc_io_top (
   input  logic                clk,
   input  logic                i_rst_n,
   input  soc_io_pkg::wb_req_t i_wb,
   output soc_io_pkg::wb_rsp_t o_wb,
   input  logic [31:0]         i_gpio,
   output logic [31:0]         o_gpio,
   input  logic                i_ram_init_done,
   input  logic                i_ram_init_error,
   input  logic                i_flash_miso,
   output logic                o_flash_sclk,
   output logic                o_flash_cs_n,
   output logic                o_flash_mosi,
   output logic                o_timer_irq,
   output soc_io_pkg::ext_irq_t o_ext_irq
);
   import soc_io_pkg::*;

   wb_req_t boot_req;
   wb_req_t sys_req;
   wb_req_t spi_req;
   wb_rsp_t boot_rsp;
   wb_rsp_t sys_rsp;
   wb_rsp_t spi_rsp;

   bus_decoder u_decoder (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_host     (i_wb),
      .o_host     (o_wb),
      .o_boot_req (boot_req),
      .o_sys_req  (sys_req),
      .o_spi_req  (spi_req),
      .i_boot_rsp (boot_rsp),
      .i_sys_rsp  (sys_rsp),
      .i_spi_rsp  (spi_rsp)
   );

   boot_mem u_boot_mem (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_req   (boot_req),
      .o_rsp   (boot_rsp)
   );

   // Software interrupt lines go straight into the irq struct
   sys_ctrl u_sys_ctrl (
      .clk              (clk),
      .i_rst_n          (i_rst_n),
      .i_req            (sys_req),
      .o_rsp            (sys_rsp),
      .i_gpio           (i_gpio),
      .o_gpio           (o_gpio),
      .i_ram_init_done  (i_ram_init_done),
      .i_ram_init_error (i_ram_init_error),
      .o_timer_irq      (o_timer_irq),
      .o_sw_irq3        (o_ext_irq.sw3),
      .o_sw_irq4        (o_ext_irq.sw4)
   );

   spi_flash_ctrl u_spi_flash (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_req   (spi_req),
      .o_rsp   (spi_rsp),
      .o_sclk  (o_flash_sclk),
      .o_cs_n  (o_flash_cs_n),
      .o_mosi  (o_flash_mosi),
      .i_miso  (i_flash_miso),
      .o_irq   (o_ext_irq.spi)
   );

endmodule

// ==== design/spi_flash_ctrl.sv ====
`timescale 1ns/100ps

module spi_flash_ctrl (
   input  logic                clk,
   input  logic                i_rst_n,
   input  soc_io_pkg::wb_req_t i_req,
   output soc_io_pkg::wb_rsp_t o_rsp,
   output logic                o_sclk,
   output logic                o_cs_n,
   output logic                o_mosi,
   input  logic                i_miso,
   output logic                o_irq
);
   import soc_io_pkg::*;

   spi_state_e           state_q;
   spi_reg_e             slot;
   logic                 wr_en;
   logic                 start;
   logic                 phase_end;
   logic                 ack_q;
   logic                 sclk_q;
   logic [SPI_DIV_W-1:0] div_cnt_q;
   logic [2:0]           bit_cnt_q;
   logic                 done_q;
   logic                 ie_q;
   logic                 sel_q;
   logic [7:0]           shift_q;
   logic [7:0]           rx_q;
   logic                 miso_q;
   logic [DATA_W-1:0]    rd_mux;
   logic [DATA_W-1:0]    rdt_q;

   // Bit 2 set lands on SPI_CTRL, so the upper half of a split 64-bit read
   // cannot touch the data register
   assign slot      = i_req.adr[2] ? SPI_CTRL : spi_reg_e'({i_req.adr[4:3], 3'b000});
   assign wr_en     = i_req.cyc & i_req.stb & i_req.we & i_req.sel[0] & ~ack_q;
   assign start     = wr_en && (slot == SPI_DATA) && (state_q == SPI_IDLE);
   assign phase_end = (div_cnt_q == SPI_DIV_W'(SPI_HALF_PERIOD - 1));

   // ************************************************
   // Control registers and shifter FSM
   // ************************************************
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state_q   <= SPI_IDLE;
         ack_q     <= 1'b0;
         sclk_q    <= 1'b0;
         div_cnt_q <= '0;
         bit_cnt_q <= '0;
         done_q    <= 1'b0;
         ie_q      <= 1'b0;
         sel_q     <= 1'b0;
      end else begin
         ack_q <= i_req.cyc & i_req.stb & ~ack_q;
         if (wr_en && slot == SPI_CTRL) ie_q <= i_req.dat[0];
         if (wr_en && slot == SPI_SEL) sel_q <= i_req.dat[0];
         if (wr_en && slot == SPI_STAT && i_req.dat[0]) done_q <= 1'b0;
         case (state_q)
            SPI_IDLE: begin
               if (start) begin
                  state_q   <= SPI_SHIFT;
                  div_cnt_q <= '0;
                  bit_cnt_q <= '0;
               end
            end
            SPI_SHIFT: begin
               if (phase_end) begin
                  div_cnt_q <= '0;
                  sclk_q    <= ~sclk_q;
                  // Falling edge closes a bit
                  if (sclk_q) begin
                     bit_cnt_q <= bit_cnt_q + 3'd1;
                     if (bit_cnt_q == 3'd7) state_q <= SPI_FINISH;
                  end
               end else begin
                  div_cnt_q <= div_cnt_q + 1'b1;
               end
            end
            SPI_FINISH: begin
               done_q  <= 1'b1;
               state_q <= SPI_IDLE;
            end
            default: state_q <= SPI_IDLE;
         endcase
      end
   end

   // Sample on rising SCLK, shift on falling, MSB first
   always_ff @(posedge clk) begin
      if (start) begin
         shift_q <= i_req.dat[7:0];
      end else if (state_q == SPI_SHIFT && phase_end && sclk_q) begin
         shift_q <= {shift_q[6:0], miso_q};
      end
      if (state_q == SPI_SHIFT && phase_end && !sclk_q) miso_q <= i_miso;
      if (state_q == SPI_FINISH) rx_q <= shift_q;
      rdt_q <= rd_mux;
   end

   always_comb begin
      case (slot)
         SPI_CTRL: rd_mux = {31'd0, ie_q};
         SPI_STAT: rd_mux = {31'd0, done_q};
         SPI_DATA: rd_mux = {24'd0, rx_q};
         SPI_SEL:  rd_mux = {31'd0, sel_q};
         default:  rd_mux = '0;
      endcase
   end

   assign o_rsp.ack = ack_q;
   assign o_rsp.rdt = ack_q ? rdt_q : '0;
   assign o_sclk    = sclk_q;
   assign o_cs_n    = ~sel_q;
   assign o_mosi    = (state_q == SPI_SHIFT) & shift_q[7];
   assign o_irq     = done_q & ie_q;

endmodule

// ==== design/sys_ctrl.sv ====
`timescale 1ns/100ps

module sys_ctrl (
   input  logic                clk,
   input  logic                i_rst_n,
   input  soc_io_pkg::wb_req_t i_req,
   output soc_io_pkg::wb_rsp_t o_rsp,
   input  logic [31:0]         i_gpio,
   output logic [31:0]         o_gpio,
   input  logic                i_ram_init_done,
   input  logic                i_ram_init_error,
   output logic                o_timer_irq,
   output logic                o_sw_irq3,
   output logic                o_sw_irq4
);
   import soc_io_pkg::*;

   sys_reg_e          reg_sel;
   logic              wr_en;
   logic              ack_q;
   logic [DATA_W-1:0] rd_mux;
   logic [DATA_W-1:0] rdt_q;
   logic [31:0]       gpio_out_q;
   logic [1:0]        swirq_q;
   logic [31:0]       mtime_q;
   logic [31:0]       mtimecmp_q;
   logic              timer_irq_q;

   assign reg_sel = sys_reg_e'(i_req.adr[$bits(sys_reg_e)-1:0]);
   assign wr_en   = i_req.cyc & i_req.stb & i_req.we & ~ack_q;

   // ************************************************
   // Register file and timer
   // ************************************************
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         ack_q       <= 1'b0;
         gpio_out_q  <= '0;
         swirq_q     <= '0;
         mtime_q     <= '0;
         mtimecmp_q  <= '1;
         timer_irq_q <= 1'b0;
      end else begin
         ack_q       <= i_req.cyc & i_req.stb & ~ack_q;
         mtime_q     <= mtime_q + 32'd1;
         timer_irq_q <= (mtime_q >= mtimecmp_q);
         if (wr_en) begin
            case (reg_sel)
               SYS_SWIRQ:    swirq_q    <= i_req.dat[1:0];
               SYS_GPIO_OUT: gpio_out_q <= i_req.dat;
               SYS_MTIMECMP: mtimecmp_q <= i_req.dat;
               default:      ;
            endcase
         end
      end
   end

   // mtime and gpio_in are read only
   always_comb begin
      case (reg_sel)
         SYS_STATUS:   rd_mux = {30'd0, i_ram_init_error, i_ram_init_done};
         SYS_SWIRQ:    rd_mux = {30'd0, swirq_q};
         SYS_GPIO_OUT: rd_mux = gpio_out_q;
         SYS_GPIO_IN:  rd_mux = i_gpio;
         SYS_MTIME:    rd_mux = mtime_q;
         SYS_MTIMECMP: rd_mux = mtimecmp_q;
         default:      rd_mux = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      rdt_q <= rd_mux;
   end

   assign o_rsp.ack   = ack_q;
   assign o_rsp.rdt   = ack_q ? rdt_q : '0;
   assign o_gpio      = gpio_out_q;
   assign o_sw_irq3   = swirq_q[0];
   assign o_sw_irq4   = swirq_q[1];
   assign o_timer_irq = timer_irq_q;

endmodule
